//--- source/sm83_bus_pkg.sv
package sm83_bus_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////
    localparam int addr_w = 16;
    localparam int data_w = 8;

    //////////////////////////////////////////////////
    // Machine cycle phases
    //////////////////////////////////////////////////
    localparam int t_w = 2;

    localparam logic [t_w-1:0] t_addr  = 2'd0; // Address setup
    localparam logic [t_w-1:0] t_wait  = 2'd1; // Memory access
    localparam logic [t_w-1:0] t_latch = 2'd2; // Data sampled at the end
    localparam logic [t_w-1:0] t_idle  = 2'd3; // Bus idle

    // Reset values
    localparam logic [addr_w-1:0] pc_reset = 16'h0000;

endpackage

//--- source/sm83_isa_pkg.sv
package sm83_isa_pkg;

    //////////////////////////////////////////////////
    // Interrupt sources and vectors
    //////////////////////////////////////////////////
    localparam int irq_n = 5;

    // Source 0 lands at 0x40, the others follow every 8 bytes
    localparam logic [sm83_bus_pkg::addr_w-1:0] irq_vec_base = 16'h0040;
    localparam logic [sm83_bus_pkg::addr_w-1:0] irq_vec_step = 16'h0008;

    //////////////////////////////////////////////////
    // Sleep opcodes
    //////////////////////////////////////////////////
    localparam logic [sm83_bus_pkg::data_w-1:0] op_halt = 8'h76;
    localparam logic [sm83_bus_pkg::data_w-1:0] op_stop = 8'h10;

    // Keypad lines, wake source in STOP
    localparam int key_w = 8;

endpackage

//--- source/mcycle_if.sv
interface mcycle_if;

    // Sequencer side
    logic [sm83_bus_pkg::t_w-1:0]    t_state;      // Current phase
    logic                            fetch_strobe; // High in t_latch of a read cycle
    logic [sm83_bus_pkg::data_w-1:0] opcode;       // Last fetched byte

    // Fetch control side
    logic [sm83_bus_pkg::addr_w-1:0] pc;
    logic                            sleep; // HALT or STOP, no reads

    modport sequencer (
        output t_state, fetch_strobe, opcode,
        input  pc, sleep
    );

    modport control (
        input  t_state, fetch_strobe, opcode,
        output pc, sleep
    );

endinterface

//--- source/irq_if.sv
interface irq_if;

    logic                            pending; // Some source enabled and IME set
    logic [sm83_bus_pkg::addr_w-1:0] vector;  // Vector of the lowest pending source
    logic                            wake;    // Sleep exit condition
    logic                            ack;     // Dispatch pulse from fetch control

    modport source (
        output pending, vector, wake,
        input  ack
    );

    modport sink (
        input  pending, vector, wake,
        output ack
    );

endinterface

//--- source/bus_sequencer.sv
module bus_sequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [sm83_bus_pkg::data_w-1:0] din,
    mcycle_if.sequencer                     m,
    output logic [sm83_bus_pkg::addr_w-1:0] a,
    output logic                            rd,
    output logic                            phi
);

    //////////////////////////////////////////////////
    // Phase counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m.t_state <= sm83_bus_pkg::t_addr;
        end else begin
            case (m.t_state)
                sm83_bus_pkg::t_addr:  m.t_state <= sm83_bus_pkg::t_wait;
                sm83_bus_pkg::t_wait:  m.t_state <= sm83_bus_pkg::t_latch;
                sm83_bus_pkg::t_latch: m.t_state <= sm83_bus_pkg::t_idle;
                default:               m.t_state <= sm83_bus_pkg::t_addr;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Bus outputs
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a   <= sm83_bus_pkg::pc_reset;
            rd  <= 1'b0;
            phi <= 1'b1;
        end else begin
            case (m.t_state)
                sm83_bus_pkg::t_addr: begin
                    a   <= m.pc;     // Held for the rest of the cycle
                    rd  <= ~m.sleep; // No fetch while sleeping
                    phi <= 1'b1;
                end
                sm83_bus_pkg::t_latch: begin
                    rd  <= 1'b0;
                    phi <= 1'b0;
                end
                default: begin
                    rd  <= rd;
                    phi <= phi;
                end
            endcase
        end
    end

    // Last clock of a reading cycle
    assign m.fetch_strobe = rd && (m.t_state == sm83_bus_pkg::t_latch);

    // Opcode latch
    always_ff @(posedge clk) begin
        if (m.fetch_strobe) begin
            m.opcode <= din;
        end
    end

endmodule

//--- source/interrupt_unit.sv
module interrupt_unit (
    input  logic [sm83_isa_pkg::irq_n-1:0] int_en,
    input  logic [sm83_isa_pkg::irq_n-1:0] int_flags_in,
    input  logic                           ime,
    input  logic [sm83_isa_pkg::key_w-1:0] key_in,
    input  logic                           sleep_stop,
    irq_if.source                          q,
    output logic [sm83_isa_pkg::irq_n-1:0] int_flags_out
);

    logic [sm83_isa_pkg::irq_n-1:0]  enabled; // Flags with their enable set
    logic [sm83_isa_pkg::irq_n-1:0]  masked;  // Enabled and IME set
    logic [sm83_isa_pkg::irq_n-1:0]  lowest;  // One-hot winner
    logic [sm83_bus_pkg::addr_w-1:0] slot;    // Vector of the source being scanned
    logic                            found;

    assign enabled = int_flags_in & int_en;
    assign masked  = enabled & {sm83_isa_pkg::irq_n{ime}};

    assign q.pending = |masked;

    //////////////////////////////////////////////////
    // Priority and vector
    //////////////////////////////////////////////////
    // Source 0 has the highest priority
    always_comb begin
        slot     = sm83_isa_pkg::irq_vec_base;
        found    = 1'b0;
        lowest   = '0;
        q.vector = sm83_isa_pkg::irq_vec_base;
        for (int i = 0; i < sm83_isa_pkg::irq_n; i++) begin
            if (masked[i] && !found) begin
                found     = 1'b1;
                lowest[i] = 1'b1;
                q.vector  = slot;
            end
            slot = slot + sm83_isa_pkg::irq_vec_step;
        end
    end

    //////////////////////////////////////////////////
    // Wake and flag clear
    //////////////////////////////////////////////////
    // HALT ignores IME, STOP also listens to the keypad
    assign q.wake = (|enabled) || (sleep_stop && (|key_in));

    // Serviced bit dropped for the dispatch clock only
    assign int_flags_out = q.ack ? (int_flags_in & ~lowest) : int_flags_in;

endmodule

//--- source/fetch_control.sv
module fetch_control (
    input  logic    clk,
    input  logic    rst,
    mcycle_if.control m,
    irq_if.sink     q,
    output logic    sleep_stop,
    output logic    done
);

    logic                            decode_q; // Opcode latch holds a real instruction
    logic [sm83_bus_pkg::addr_w-1:0] pc_next_seq;
    logic                            wake_slot;

    assign pc_next_seq = m.pc + {{(sm83_bus_pkg::addr_w-1){1'b0}}, 1'b1};

    // Interrupt taken in place of the fetched instruction
    assign q.ack = m.fetch_strobe && q.pending;

    // Wake is checked once per machine cycle
    assign wake_slot = m.sleep && (m.t_state == sm83_bus_pkg::t_latch);

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m.pc     <= sm83_bus_pkg::pc_reset;
            decode_q <= 1'b0;
        end else begin
            decode_q <= 1'b0;
            if (m.fetch_strobe) begin
                if (q.pending) begin
                    m.pc <= q.vector; // Opcode dropped
                end else begin
                    m.pc     <= pc_next_seq;
                    decode_q <= 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // HALT and STOP
    //////////////////////////////////////////////////
    // The opcode is compared in t_idle right after the latch,
    // well before the next address phase samples sleep
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m.sleep    <= 1'b0;
            sleep_stop <= 1'b0;
        end else if (m.sleep) begin
            if (wake_slot && q.wake) begin
                m.sleep    <= 1'b0; // Next cycle refetches at pc
                sleep_stop <= 1'b0;
            end
        end else if (decode_q) begin
            if (m.opcode == sm83_isa_pkg::op_halt) begin
                m.sleep <= 1'b1;
            end else if (m.opcode == sm83_isa_pkg::op_stop) begin
                m.sleep    <= 1'b1;
                sleep_stop <= 1'b1;
            end
        end
    end

    // Sleep indication, one clock behind
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= m.sleep;
        end
    end

endmodule

//--- source/cpu_frontend.sv
module cpu_frontend (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [sm83_bus_pkg::data_w-1:0] din,
    input  logic [sm83_isa_pkg::irq_n-1:0]  int_en,
    input  logic [sm83_isa_pkg::irq_n-1:0]  int_flags_in,
    input  logic                            ime,
    input  logic [sm83_isa_pkg::key_w-1:0]  key_in,
    output logic [sm83_bus_pkg::addr_w-1:0] a,
    output logic                            rd,
    output logic                            phi,
    output logic [sm83_isa_pkg::irq_n-1:0]  int_flags_out,
    output logic                            done
);

    logic sleep_stop; // STOP flavour of sleep

    mcycle_if m_bus ();
    irq_if    q_irq ();

    //////////////////////////////////////////////////
    // Machine cycle and bus
    //////////////////////////////////////////////////
    bus_sequencer u_bus_sequencer (
        .clk (clk),
        .rst (rst),
        .din (din),
        .m   (m_bus),
        .a   (a),
        .rd  (rd),
        .phi (phi)
    );

    //////////////////////////////////////////////////
    // Interrupts and wake
    //////////////////////////////////////////////////
    interrupt_unit u_interrupt_unit (
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .ime           (ime),
        .key_in        (key_in),
        .sleep_stop    (sleep_stop),
        .q             (q_irq),
        .int_flags_out (int_flags_out)
    );

    // PC, sleep and dispatch
    fetch_control u_fetch_control (
        .clk        (clk),
        .rst        (rst),
        .m          (m_bus),
        .q          (q_irq),
        .sleep_stop (sleep_stop),
        .done       (done)
    );

endmodule

//--- dv/cpu_frontend_properties.sv
module cpu_frontend_properties (
    input logic                            clk,
    input logic                            rst,
    input logic [sm83_bus_pkg::addr_w-1:0] a,
    input logic                            rd,
    input logic                            phi,
    input logic                            done,
    input logic [sm83_isa_pkg::irq_n-1:0]  int_flags_in,
    input logic [sm83_isa_pkg::irq_n-1:0]  int_flags_out
);

    timeunit 1ns;
    timeprecision 1ps;

    // Read strobe only inside the high half of phi
    rd_within_phi: assert property (@(posedge clk) disable iff (rst) rd |-> phi)
        else $error("rd high while phi is low");

    // Address held for the whole read
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        rd && $past(rd) |-> $stable(a))
        else $error("address moved while rd was high");

    no_read_asleep: assert property (@(posedge clk) disable iff (rst) !(rd && done))
        else $error("rd and done high together");

    // Flags can only be cleared, never set
    flags_only_cleared: assert property (@(posedge clk) disable iff (rst)
        (int_flags_out & ~int_flags_in) == '0)
        else $error("int_flags_out set a bit missing from int_flags_in");

endmodule

bind cpu_frontend cpu_frontend_properties u_properties (
    .clk           (clk),
    .rst           (rst),
    .a             (a),
    .rd            (rd),
    .phi           (phi),
    .done          (done),
    .int_flags_in  (int_flags_in),
    .int_flags_out (int_flags_out)
);

//--- dv/cpu_frontend_tb.sv
module cpu_frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                            clk;
    logic                            rst;
    logic [sm83_bus_pkg::data_w-1:0] din = '0;
    logic [sm83_isa_pkg::irq_n-1:0]  int_en;
    logic [sm83_isa_pkg::irq_n-1:0]  int_flags_in;
    logic                            ime;
    logic [sm83_isa_pkg::key_w-1:0]  key_in;
    logic [sm83_bus_pkg::addr_w-1:0] a;
    logic                            rd;
    logic                            phi;
    logic [sm83_isa_pkg::irq_n-1:0]  int_flags_out;
    logic                            done;

    logic [sm83_bus_pkg::data_w-1:0] mem [0:255]; // Program memory
    logic [31:0]                     lfsr;
    logic [sm83_bus_pkg::addr_w-1:0] exp_addr;    // Predicted next fetch
    logic                            rd_last;
    logic                            done_seen;   // Sleep seen since the last fetch
    logic                            sleep_due;
    int rd_len;
    int gap;
    int fetches;
    int dispatches;
    int errors;      // Compare process
    int flow_errors; // Stimulus sequence
    int timeouts;

    cpu_frontend dut0 (
        .clk           (clk),
        .rst           (rst),
        .din           (din),
        .int_en        (int_en),
        .int_flags_in  (int_flags_in),
        .ime           (ime),
        .key_in        (key_in),
        .a             (a),
        .rd            (rd),
        .phi           (phi),
        .int_flags_out (int_flags_out),
        .done          (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory answers within the cycle
    always @(posedge clk) begin
        din <= mem[a[7:0]];
    end

    //////////////////////////////////////////////////
    // Stimulus data
    //////////////////////////////////////////////////
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            b[i] = lfsr[0]; // One step per bit
            lfsr = lfsr_step(lfsr);
        end
        return b;
    endfunction

    task automatic fill_memory();
        logic [7:0] b;
        lfsr = 32'ha77b247a;
        for (int i = 0; i < 256; i++) begin
            b = random_byte();
            if (b == sm83_isa_pkg::op_halt || b == sm83_isa_pkg::op_stop) begin
                b = b ^ 8'h01;
            end
            mem[i] = b;
        end
        mem[8'h0c] = sm83_isa_pkg::op_halt;
        mem[8'h1a] = sm83_isa_pkg::op_stop;
    endtask

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////
    // Returns {sleep begins, next fetch address}
    function automatic logic [16:0] expected_next(
        input logic [15:0] pc,
        input logic [7:0]  op,
        input logic [4:0]  flags,
        input logic [4:0]  en,
        input logic        ie
    );
        logic [15:0] next;
        logic        sleep;
        next  = pc + 16'd1;
        sleep = (op == sm83_isa_pkg::op_halt) || (op == sm83_isa_pkg::op_stop);
        // Scan downward so the lowest source is the last one written
        for (int i = sm83_isa_pkg::irq_n - 1; i >= 0; i--) begin
            if (ie && flags[i] && en[i]) begin
                next  = sm83_isa_pkg::irq_vec_base + 16'(i) * sm83_isa_pkg::irq_vec_step;
                sleep = 1'b0; // Opcode thrown away
            end
        end
        return {sleep, next};
    endfunction

    function automatic logic [4:0] serviced_flags(
        input logic [4:0] flags,
        input logic [4:0] en,
        input logic       ie
    );
        logic [4:0] result;
        logic       hit;
        result = flags;
        hit    = 1'b0;
        for (int i = 0; i < sm83_isa_pkg::irq_n; i++) begin
            if (ie && flags[i] && en[i] && !hit) begin
                result[i] = 1'b0;
                hit       = 1'b1;
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////
    always @(negedge clk) begin : compare_fetch
        logic [16:0] pred;
        logic [4:0]  flags_exp;
        if (rst) begin
            exp_addr  = sm83_bus_pkg::pc_reset;
            rd_last   = 1'b0;
            rd_len    = 0;
            gap       = 0;
            done_seen = 1'b0;
            sleep_due = 1'b0;
        end else begin
            flags_exp = int_flags_in;
            gap       = gap + 1;
            if (done) begin
                done_seen = 1'b1;
            end
            if (rd && !rd_last) begin // New fetch address on the bus
                assert (a == exp_addr) else begin
                    errors++;
                    $display("ERROR %0t: fetch at %h, expected %h", $time, a, exp_addr);
                end
                assert (fetches == 0 || sleep_due || gap == 4) else begin
                    errors++;
                    $display("ERROR %0t: fetch %0d clocks after the last one", $time, gap);
                end
                assert (sleep_due == done_seen) else begin
                    errors++;
                    $display("ERROR %0t: fetch at %h, sleep seen %0b, expected %0b",
                             $time, a, done_seen, sleep_due);
                end
                fetches++;
                gap       = 0;
                done_seen = 1'b0;
                sleep_due = 1'b0;
            end
            if (rd && rd_last) begin // t_latch, decision at the coming edge
                pred      = expected_next(exp_addr, mem[exp_addr[7:0]], int_flags_in,
                                          int_en, ime);
                exp_addr  = pred[15:0];
                sleep_due = pred[16];
                flags_exp = serviced_flags(int_flags_in, int_en, ime);
                if (ime && (int_flags_in & int_en) != '0) begin
                    dispatches++;
                end
            end
            if (!rd && rd_last) begin
                assert (rd_len == 2) else begin
                    errors++;
                    $display("ERROR %0t: rd high for %0d clocks", $time, rd_len);
                end
            end
            assert (int_flags_out == flags_exp) else begin
                errors++;
                $display("ERROR %0t: int_flags_out %b, expected %b", $time, int_flags_out,
                         flags_exp);
            end
            rd_len  = rd ? rd_len + 1 : 0;
            rd_last = rd;
        end
    end

    //////////////////////////////////////////////////
    // Waits and run control
    //////////////////////////////////////////////////
    task automatic finish_run();
        $display("Fetches %0d, dispatches %0d, errors %0d, flow errors %0d, timeouts %0d",
                 fetches, dispatches, errors, flow_errors, timeouts);
        if (errors == 0 && flow_errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    task automatic wait_for_level(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (done !== level && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (done !== level) begin
            timeouts++;
            $display("Timeout: done never went to %0b during %s", level, what);
            finish_run();
        end
    endtask

    task automatic run_fetches(input int count, input int limit);
        int target;
        int n;
        target = fetches + count;
        n      = 0;
        while (fetches < target && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (fetches < target) begin
            timeouts++;
            $display("Timeout: the core stopped fetching");
            finish_run();
        end
    endtask

    task automatic await_dispatch(input int limit);
        int n;
        n = 0;
        while (dispatches == 0 && n < limit) begin
            @(posedge clk);
            n++;
        end
        if (dispatches == 0) begin
            timeouts++;
            $display("Timeout: no interrupt was dispatched");
            finish_run();
        end
    endtask

    task automatic hold_asleep(input int clocks, input string what);
        repeat (clocks) begin
            @(negedge clk);
            assert (done && !rd) else begin
                flow_errors++;
                $display("ERROR %0t: core awake during %s", $time, what);
            end
        end
    endtask

    initial begin
        rst          = 1'b1;
        int_en       = '0;
        int_flags_in = '0;
        ime          = 1'b0;
        key_in       = '0;
        fetches      = 0;
        dispatches   = 0;
        errors       = 0;
        flow_errors  = 0;
        timeouts     = 0;
        fill_memory();
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        @(negedge clk);
        assert (!rd && !done && phi && a == sm83_bus_pkg::pc_reset
                && int_flags_out == int_flags_in) else begin
            flow_errors++;
            $display("ERROR %0t: outputs wrong after reset", $time);
        end

        // Straight-line fetches up to the HALT at 0x0c
        wait_for_level(1'b1, 200, "HALT entry");
        hold_asleep(12, "HALT");
        @(posedge clk);
        int_flags_in <= 5'b00100; // Flag set but disabled
        hold_asleep(12, "HALT with a disabled flag");
        @(posedge clk);
        int_en <= 5'b00100;
        wait_for_level(1'b0, 20, "HALT wake");
        @(posedge clk);
        int_flags_in <= '0;
        int_en       <= '0;

        // STOP at 0x1a, keypad only
        wait_for_level(1'b1, 200, "STOP entry");
        hold_asleep(8, "STOP");
        @(posedge clk);
        key_in <= 8'h04;
        wait_for_level(1'b0, 20, "STOP wake");
        @(posedge clk);
        key_in <= '0;

        @(posedge clk);
        ime          <= 1'b1;
        int_flags_in <= 5'b00001;
        run_fetches(3, 40);
        @(posedge clk);
        int_en       <= 5'b11110;
        int_flags_in <= 5'b10110; // Source 1 wins
        await_dispatch(20);
        int_flags_in <= '0;
        ime          <= 1'b0;
        run_fetches(2, 40);
        finish_run();
    end

endmodule

//--- verilog.f
source/sm83_bus_pkg.sv
source/sm83_isa_pkg.sv
source/mcycle_if.sv
source/irq_if.sv
source/bus_sequencer.sv
source/interrupt_unit.sv
source/fetch_control.sv
source/cpu_frontend.sv
dv/cpu_frontend_properties.sv
dv/cpu_frontend_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module cpu_frontend_tb -Mdir obj_dir \
    && ./obj_dir/Vcpu_frontend_tb | tee /dev/stderr \
    | grep -x "Simulation passed" > /dev/null \
    && { echo "Run OK"; exit 0; } \
    || { echo "Run FAILED"; exit 1; }
